/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = alu_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* files.f */
src/alu_pkg.sv
src/alu_issue_ctrl.sv
src/alu_cycle_timer.sv
src/alu_logic_unit.sv
src/alu_multiplier.sv
src/alu_divider.sv
src/alu_unit.sv
sim/alu_clk_gen.sv
sim/alu_tb.sv

/* sim/alu_clk_gen.sv */
// Free-running testbench clock with a period of 4 time units
module alu_clk_gen (
	output logic clk
);

	localparam int HALF_PERIOD = 2;

	initial
	begin
		clk = 1'b0;
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

/* sim/alu_tb.sv */
// Testbench for the integer execute unit
// Reference model, stimulus driver, result checker and watchdog
module alu_tb;
	import alu_pkg::*;

	localparam int N_SIMPLE = 60;
	localparam int N_CMP = 48;
	localparam int N_MUL = 39;
	localparam int N_DIV = 52;
	localparam int N_BURST = 12;
	localparam int NUM_TESTS = N_SIMPLE + N_CMP + N_MUL + N_DIV + N_BURST;
	localparam int WAIT_LIMIT = DIV_CYCLES + 4;

	localparam alu_op_e LOGIC_OPS[3] = '{OP_AND, OP_OR, OP_EOR};
	localparam alu_op_e CMP_OPS[6] = '{OP_SEQ, OP_SLT, OP_SLTU, OP_MAX3, OP_MIN3, OP_MID3};
	localparam alu_op_e MUL_OPS[3] = '{OP_MUL, OP_MULU, OP_MULH};
	localparam alu_op_e DIV_OPS[4] = '{OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
	localparam alu_op_e SIMPLE_OPS[9] = '{OP_ADD3, OP_SUB3, OP_ADDI, OP_AND, OP_OR, OP_EOR,
		OP_SHL, OP_SHR, OP_ASR};
	localparam logic [WID-1:0] EXTREMES[5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
		32'h8000_0000, 32'h7fff_ffff};

	logic clk;
	logic rst;
	logic issue;
	alu_op_e op;
	alu_mod_e modf;
	logic [WID-1:0] a;
	logic [WID-1:0] b;
	logic [WID-1:0] c;
	logic [IMMW-1:0] imm;
	logic [WID-1:0] result;
	logic result_valid;
	logic div_by_zero;
	logic busy;

	// Outstanding operations with the oldest first
	logic [WID:0] want_q[$];
	int lat_q[$];
	int cyc_q[$];
	string desc_q[$];

	int neg_cnt = 0;
	int checks = 0;
	int err_value = 0;
	int err_timing = 0;
	int err_missing = 0;

	alu_clk_gen u_clk (
		.clk(clk)
	);

	alu_unit uut (
		.clk(clk), .rst(rst), .issue(issue), .op(op), .modf(modf),
		.a(a), .b(b), .c(c), .imm(imm), .result(result),
		.result_valid(result_valid), .div_by_zero(div_by_zero), .busy(busy)
	);

	// ======================================================================
	// Reference model that returns {div_by_zero, result}
	// ======================================================================
	function automatic logic [WID:0] ref_alu(
		input alu_op_e         f_op,
		input alu_mod_e        f_mod,
		input logic [WID-1:0]  x,
		input logic [WID-1:0]  y,
		input logic [WID-1:0]  z,
		input logic [IMMW-1:0] k
	);
		logic [WID-1:0] ab;
		logic [WID-1:0] r;
		logic [63:0] p;
		longint sx;
		longint sy;
		longint sz;
		longint hi;
		longint lo;
		logic dbz;

		sx = longint'($signed(x));
		sy = longint'($signed(y));
		sz = longint'($signed(z));
		ab = (f_op == OP_AND) ? (x & y) : ((f_op == OP_OR) ? (x | y) : (x ^ y));
		hi = (sx > sy) ? sx : sy;
		hi = (hi > sz) ? hi : sz;
		lo = (sx < sy) ? sx : sy;
		lo = (lo < sz) ? lo : sz;
		if (f_op == OP_MULU)
			p = {32'd0, x} * {32'd0, y};
		else
			p = sx * sy;
		dbz = (f_op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU}) && (y == '0);
		case (f_op)
			OP_ADD3: r = x + y + z;
			OP_SUB3: r = x - y - z;
			OP_ADDI: r = WID'(sx + longint'($signed(k)));
			OP_SEQ: r = (x == y) ? z : '0;
			OP_SLT: r = (sx < sy) ? z : '0;
			OP_SLTU: r = (x < y) ? z : '0;
			OP_MAX3: r = WID'(hi);
			OP_MIN3: r = WID'(lo);
			// The median is whatever is left once the extremes are taken out
			OP_MID3: r = WID'(sx + sy + sz - hi - lo);
			OP_SHL: r = x << z[4:0];
			OP_SHR: r = x >> z[4:0];
			OP_ASR: r = WID'(sx >>> z[4:0]);
			OP_MUL, OP_MULU: r = p[WID-1:0];
			OP_MULH: r = p[2*WID-1:WID];
			OP_DIV: r = dbz ? '1 : WID'(sx / sy);
			OP_MOD: r = dbz ? x : WID'(sx % sy);
			OP_DIVU: r = dbz ? '1 : x / y;
			OP_MODU: r = dbz ? x : x % y;
			OP_AND, OP_OR, OP_EOR:
			begin
				case (f_mod)
					MOD_AND: r = ab & z;
					MOD_ANDN: r = ab & ~z;
					MOD_OR: r = ab | z;
					MOD_ORN: r = ab | ~z;
					MOD_XOR: r = ab ^ z;
					default: r = ~(ab ^ z);
				endcase
			end
			default: r = '0;
		endcase
		return {dbz, r};
	endfunction

	function automatic int latency_of(input alu_op_e f_op);
		if (f_op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU})
			return DIV_CYCLES + 2;
		if (f_op inside {OP_MUL, OP_MULU, OP_MULH})
			return MUL_LAT + 1;
		return 1;
	endfunction

	function automatic alu_op_e pick_simple();
		return SIMPLE_OPS[$urandom_range(8)];
	endfunction

	function automatic alu_mod_e pick_mod();
		return alu_mod_e'($urandom_range(5));
	endfunction

	// ======================================================================
	// Driver tasks
	// ======================================================================
	// Drives one issue from a rising edge and queues its expected outcome
	task automatic send_op(
		input alu_op_e         s_op,
		input alu_mod_e        s_mod,
		input logic [WID-1:0]  sa,
		input logic [WID-1:0]  sb,
		input logic [WID-1:0]  sc,
		input logic [IMMW-1:0] si
	);
		issue <= 1'b1;
		op <= s_op;
		modf <= s_mod;
		a <= sa;
		b <= sb;
		c <= sc;
		imm <= si;
		want_q.push_back(ref_alu(s_op, s_mod, sa, sb, sc, si));
		lat_q.push_back(latency_of(s_op));
		// The issue is visible to the checker from the next falling edge
		cyc_q.push_back(neg_cnt + 1);
		desc_q.push_back($sformatf("%s/%s a=%h b=%h c=%h imm=%h",
			s_op.name(), s_mod.name(), sa, sb, sc, si));
	endtask

	task automatic wait_results();
		int waited;

		waited = 0;
		while ((want_q.size() > 0) && (waited < WAIT_LIMIT))
		begin
			@(posedge clk);
			waited++;
		end
		if (want_q.size() > 0)
		begin
			$display("No result_valid within %0d cycles for %s", WAIT_LIMIT, desc_q[0]);
			err_missing += want_q.size();
			want_q.delete();
			lat_q.delete();
			cyc_q.delete();
			desc_q.delete();
		end
	endtask

	task automatic run_op(
		input alu_op_e         r_op,
		input alu_mod_e        r_mod,
		input logic [WID-1:0]  ra,
		input logic [WID-1:0]  rb,
		input logic [WID-1:0]  rc,
		input logic [IMMW-1:0] ri
	);
		@(posedge clk);
		send_op(r_op, r_mod, ra, rb, rc, ri);
		@(posedge clk);
		issue <= 1'b0;
		wait_results();
	endtask

	// Issues simple ops on consecutive cycles and expects one result pulse for each
	task automatic run_burst(input int n);
		for (int k = 0; k < n; k++)
		begin
			@(posedge clk);
			send_op(pick_simple(), pick_mod(), $urandom(), $urandom(), $urandom(),
				IMMW'($urandom()));
		end
		@(posedge clk);
		issue <= 1'b0;
		wait_results();
	endtask

	// ======================================================================
	// Result checker sampled on the falling edge
	// ======================================================================
	always @(negedge clk)
	begin
		logic [WID:0] want;
		int lat;
		int lat_want;
		logic busy_want;
		string desc;

		neg_cnt = neg_cnt + 1;
		if (rst === 1'b0)
		begin
			busy_want = (cyc_q.size() > 0) && (lat_q[0] > 1) && (neg_cnt > cyc_q[0]);
			if (busy !== busy_want)
			begin
				$display("Fail at %0t: busy is %b, expected %b", $time, busy, busy_want);
				err_timing++;
			end
			if (result_valid === 1'b1)
			begin
				if (want_q.size() == 0)
				begin
					$display("Unexpected result_valid at time %0t with nothing outstanding",
						$time);
					err_timing++;
				end
				else
				begin
					want = want_q.pop_front();
					lat_want = lat_q.pop_front();
					lat = neg_cnt - cyc_q.pop_front();
					desc = desc_q.pop_front();
					checks++;
					if ((result !== want[WID-1:0]) || (div_by_zero !== want[WID]))
					begin
						$display("Fail at %0t: %s gave %h dbz %b, expected %h dbz %b", $time,
							desc, result, div_by_zero, want[WID-1:0], want[WID]);
						err_value++;
					end
					if (lat != lat_want)
					begin
						$display("Wrong latency at time %0t: %s took %0d cycles instead of %0d",
							$time, desc, lat, lat_want);
						err_timing++;
					end
				end
			end
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial
	begin
		int seed_ret;
		logic [WID-1:0] ra;
		logic [WID-1:0] rb;
		logic [WID-1:0] rc;

		seed_ret = $urandom(6592);
		rst = 1'b1;
		issue = 1'b0;
		op = OP_ADD3;
		modf = MOD_AND;
		a = '0;
		b = '0;
		c = '0;
		imm = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if ((result_valid !== 1'b0) || (busy !== 1'b0))
		begin
			$display("result_valid or busy is not low after reset");
			err_timing++;
		end

		// Every modifier of every logic op comes first and random simple ops follow
		for (int m = 0; m < 18; m++)
			run_op(LOGIC_OPS[m / 6], alu_mod_e'(m % 6), $urandom(), $urandom(), $urandom(), '0);
		for (int k = 18; k < N_SIMPLE; k++)
			run_op(pick_simple(), pick_mod(), $urandom(), $urandom(), $urandom(),
				IMMW'($urandom()));

		for (int k = 0; k < N_CMP; k++)
		begin
			ra = $urandom();
			rb = $urandom();
			rc = $urandom();
			// Equal operands exercise the tie cases of every compare
			case ((k / 6) % 4)
				1: rb = ra;
				2: rc = ra;
				3:
				begin
					rb = ra;
					rc = ra;
				end
				default: ;
			endcase
			run_op(CMP_OPS[k % 6], MOD_AND, ra, rb, rc, '0);
		end

		for (int k = 0; k < 15; k++)
			run_op(MUL_OPS[k % 3], MOD_AND, EXTREMES[k % 5], EXTREMES[(k + 2) % 5], '0, '0);
		for (int k = 15; k < N_MUL; k++)
			run_op(MUL_OPS[k % 3], MOD_AND, $urandom(), $urandom(), '0, '0);

		for (int k = 0; k < 40; k++)
		begin
			ra = $urandom();
			// Narrow divisors give quotients of every size
			rb = $urandom() >> $urandom_range(31);
			if (rb == '0)
				rb = 32'd3;
			if ($urandom_range(1) == 1)
				rb = -rb;
			run_op(DIV_OPS[k % 4], MOD_AND, ra, rb, '0, '0);
		end
		run_op(OP_DIV, MOD_AND, 32'h8000_0000, 32'hffff_ffff, '0, '0);
		run_op(OP_MOD, MOD_AND, 32'h8000_0000, 32'hffff_ffff, '0, '0);
		run_op(OP_DIV, MOD_AND, 32'hffff_fff9, 32'd2, '0, '0);
		run_op(OP_MOD, MOD_AND, 32'hffff_fff9, 32'd2, '0, '0);
		for (int k = 0; k < 8; k++)
			run_op(DIV_OPS[k % 4], MOD_AND, $urandom(), '0, '0, '0);

		run_burst(6);
		run_burst(6);

		repeat (4) @(posedge clk);
		$display("Checks: %0d, value errors: %0d, timing errors: %0d, missing results: %0d",
			checks, err_value, err_timing, err_missing);
		if ((err_value + err_timing + err_missing) == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Upper bound on the run length derived from the number of operations
	initial
	begin
		repeat (NUM_TESTS * (DIV_CYCLES + 4) + 100) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the test did not complete",
			NUM_TESTS * (DIV_CYCLES + 4) + 100);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* src/alu_cycle_timer.sv */
// Loadable down-counter that flags the last cycle of a multi-cycle operation
module alu_cycle_timer (
	input  logic       clk,
	input  logic       rst,
	input  logic       load,
	input  logic [7:0] value,
	output logic       expired
);

	logic [7:0] count;
	logic armed;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= 8'd0;
			armed <= 1'b0;
		end
		else if (load)
		begin
			// A reload restarts the count from the new value
			count <= value;
			armed <= 1'b1;
		end
		else if (armed)
		begin
			if (count == 8'd0)
				armed <= 1'b0;
			else
				count <= count - 8'd1;
		end
	end

	// High for the single cycle in which an armed count sits at zero
	assign expired = armed && (count == 8'd0);

	a_expired_pulse: assert property (@(posedge clk) disable iff (rst)
		expired |=> !expired);

endmodule

/* src/alu_divider.sv */
// Radix-2 restoring divider with sign handling and divide-by-zero detection
module alu_divider (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    sgn,
	input  logic [alu_pkg::WID-1:0] a,
	input  logic [alu_pkg::WID-1:0] b,
	output logic [alu_pkg::WID-1:0] quotient,
	output logic [alu_pkg::WID-1:0] remainder,
	output logic                    dbz,
	output logic                    done
);
	import alu_pkg::*;

	logic [WID-1:0] quo;
	logic [WID-1:0] rem;
	logic [WID-1:0] dvs;
	logic [DIV_CNTW-1:0] cnt;
	logic run;
	logic neg_q;
	logic neg_r;
	logic [WID-1:0] a_mag;
	logic [WID-1:0] b_mag;
	logic [WID:0] shifted;
	logic [WID+1:0] trial;

	assign a_mag = (sgn && a[WID-1]) ? -a : a;
	assign b_mag = (sgn && b[WID-1]) ? -b : b;

	// The dividend shifts out of quo while quotient bits shift in
	assign shifted = {rem, quo[WID-1]};
	assign trial = {1'b0, shifted} - {2'b00, dvs};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			run <= 1'b0;
			cnt <= '0;
			dbz <= 1'b0;
		end
		else if (start)
		begin
			run <= 1'b1;
			cnt <= DIV_CNTW'(DIV_CYCLES);
			dbz <= (b == '0);
			neg_q <= (b != '0) && sgn && (a[WID-1] ^ b[WID-1]);
			neg_r <= (b != '0) && sgn && a[WID-1];
			quo <= (b == '0) ? '1 : a_mag;
			rem <= (b == '0) ? a : '0;
			dvs <= b_mag;
		end
		else if (run)
		begin
			if (cnt == '0)
				run <= 1'b0;
			else
			begin
				cnt <= cnt - 1'b1;
				// A zero divisor keeps its preset result through the count
				if (!dbz)
				begin
					if (!trial[WID+1])
					begin
						rem <= trial[WID-1:0];
						quo <= {quo[WID-2:0], 1'b1};
					end
					else
					begin
						rem <= shifted[WID-1:0];
						quo <= {quo[WID-2:0], 1'b0};
					end
				end
			end
		end
	end

	// Sign restore happens in the final cycle, when done is high
	assign done = run && (cnt == '0);
	assign quotient = neg_q ? -quo : quo;
	assign remainder = neg_r ? -rem : rem;

	a_no_start_running: assert property (@(posedge clk) disable iff (rst)
		start |-> !run);

endmodule

/* src/alu_issue_ctrl.sv */
// Issue sequencing FSM for simple, multiply and divide operations
// Drives unit start strobes, the cycle timer, busy and result_valid
module alu_issue_ctrl (
	input  logic             clk,
	input  logic             rst,
	input  logic             issue,
	input  alu_pkg::alu_op_e op,
	input  logic             expired,
	output logic             mul_start,
	output logic             div_start,
	output logic             timer_load,
	output logic [7:0]       timer_value,
	output logic             busy,
	output logic             result_valid
);
	import alu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_MUL,
		WAIT_DIV
	} state_e;

	state_e state;
	logic accept;
	logic take_mul;
	logic take_div;
	logic simple_done;

	assign accept = issue && (state == IDLE);
	assign take_mul = accept && is_mul_op(op);
	assign take_div = accept && is_div_op(op);

	// The timer is loaded in the issue cycle so it lines up with the result
	assign timer_load = take_mul || take_div;
	assign timer_value = take_div ? 8'(DIV_CYCLES + 1) : 8'(MUL_LAT);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			simple_done <= 1'b0;
		end
		else
		begin
			// Units start one cycle late, once the operand registers hold the issue
			mul_start <= take_mul;
			div_start <= take_div;
			simple_done <= accept && !take_mul && !take_div;
			case (state)
				IDLE:
				begin
					if (take_mul)
						state <= WAIT_MUL;
					else if (take_div)
						state <= WAIT_DIV;
				end
				WAIT_MUL, WAIT_DIV:
				begin
					if (expired)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	assign busy = (state != IDLE);
	assign result_valid = simple_done || (busy && expired);

	// The issuing side must wait for the multi-cycle result
	a_no_issue_busy: assert property (@(posedge clk) disable iff (rst) issue |-> !busy);

	// The timer only runs for an operation the FSM is waiting on
	a_no_idle_expiry: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE) |-> !expired);

endmodule

/* src/alu_logic_unit.sv */
// Combinational datapath for the single-cycle operations
// Adds, modified logic ops, compare-set, three-way select, shifts
module alu_logic_unit (
	input  alu_pkg::alu_op_e         op,
	input  alu_pkg::alu_mod_e        modf,
	input  logic [alu_pkg::WID-1:0]  a,
	input  logic [alu_pkg::WID-1:0]  b,
	input  logic [alu_pkg::WID-1:0]  c,
	input  logic [alu_pkg::IMMW-1:0] imm,
	output logic [alu_pkg::WID-1:0]  y
);
	import alu_pkg::*;

	logic [WID-1:0] imm_ext;
	logic [WID-1:0] max_ab;
	logic [WID-1:0] min_ab;
	logic [WID-1:0] max3;
	logic [WID-1:0] min3;
	logic [WID-1:0] cap_mid;
	logic [WID-1:0] mid3;
	logic [4:0] shamt;

	// Second logic stage that applies c to the a/b result
	function automatic logic [WID-1:0] apply_mod(
		input logic [WID-1:0] x,
		input logic [WID-1:0] m,
		input alu_mod_e       sel
	);
		case (sel)
			MOD_AND:  return x & m;
			MOD_ANDN: return x & ~m;
			MOD_OR:   return x | m;
			MOD_ORN:  return x | ~m;
			MOD_XOR:  return x ^ m;
			MOD_XNOR: return x ^ ~m;
			default:  return '0;
		endcase
	endfunction

	assign imm_ext = {{(WID-IMMW){imm[IMMW-1]}}, imm};
	assign shamt = c[4:0];

	// ======================================================================
	// Signed three-way select
	// ======================================================================
	assign max_ab = ($signed(a) > $signed(b)) ? a : b;
	assign min_ab = ($signed(a) > $signed(b)) ? b : a;
	assign max3 = ($signed(max_ab) > $signed(c)) ? max_ab : c;
	assign min3 = ($signed(min_ab) < $signed(c)) ? min_ab : c;

	// Median is the larger of min(a,b) and min(max(a,b),c)
	assign cap_mid = ($signed(max_ab) < $signed(c)) ? max_ab : c;
	assign mid3 = ($signed(min_ab) > $signed(cap_mid)) ? min_ab : cap_mid;

	// ======================================================================
	// Result select
	// ======================================================================
	always_comb
	begin
		case (op)
			OP_ADD3: y = a + b + c;
			OP_SUB3: y = a - b - c;
			OP_ADDI: y = a + imm_ext;
			OP_AND:  y = apply_mod(a & b, c, modf);
			OP_OR:   y = apply_mod(a | b, c, modf);
			OP_EOR:  y = apply_mod(a ^ b, c, modf);
			OP_SEQ:  y = (a == b) ? c : '0;
			OP_SLT:  y = ($signed(a) < $signed(b)) ? c : '0;
			OP_SLTU: y = (a < b) ? c : '0;
			OP_MAX3: y = max3;
			OP_MIN3: y = min3;
			OP_MID3: y = mid3;
			OP_SHL:  y = a << shamt;
			OP_SHR:  y = a >> shamt;
			OP_ASR:  y = $signed(a) >>> shamt;
			// Multi-cycle ops are answered by their own units
			default: y = '0;
		endcase
	end

endmodule

/* src/alu_multiplier.sv */
// Three-stage signed/unsigned multiplier pipeline with low/high half select
module alu_multiplier (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    sgn,
	input  logic                    high,
	input  logic [alu_pkg::WID-1:0] a,
	input  logic [alu_pkg::WID-1:0] b,
	output logic [alu_pkg::WID-1:0] product,
	output logic                    done
);
	import alu_pkg::*;

	logic [WID:0] a_s1;
	logic [WID:0] b_s1;
	logic high_s1;
	logic high_s2;
	logic signed [2*WID+1:0] full;
	logic [2*WID-1:0] prod_s2;
	logic [MUL_LAT-1:0] vld;

	// One extra bit makes a single signed multiplier serve both modes
	assign full = $signed(a_s1) * $signed(b_s1);

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			a_s1 <= {sgn & a[WID-1], a};
			b_s1 <= {sgn & b[WID-1], b};
			high_s1 <= high;
		end
		if (vld[0])
		begin
			prod_s2 <= full[2*WID-1:0];
			high_s2 <= high_s1;
		end
		if (vld[1])
			product <= high_s2 ? prod_s2[2*WID-1:WID] : prod_s2[WID-1:0];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[MUL_LAT-2:0], start};
	end

	assign done = vld[MUL_LAT-1];

endmodule

/* src/alu_pkg.sv */
// Widths, latencies and operation codes of the integer execute unit
// Opcode class helpers for the issue controller and the top level
package alu_pkg;

	// ======================================================================
	// Widths and latencies
	// ======================================================================
	localparam int WID = 32;
	localparam int OPW = 5;
	localparam int MODW = 3;
	localparam int IMMW = 12;

	// Multiplier pipeline depth in stages
	localparam int MUL_LAT = 3;

	// One restoring step per result bit
	localparam int DIV_CYCLES = WID;
	localparam int DIV_CNTW = $clog2(DIV_CYCLES + 1);

	// ======================================================================
	// Operation codes
	// ======================================================================
	typedef enum logic [OPW-1:0] {
		OP_ADD3, OP_SUB3, OP_AND, OP_OR, OP_EOR,
		OP_SEQ, OP_SLT, OP_SLTU,
		OP_MAX3, OP_MIN3, OP_MID3,
		OP_SHL, OP_SHR, OP_ASR, OP_ADDI,
		OP_MUL, OP_MULU, OP_MULH,
		OP_DIV, OP_DIVU, OP_MOD, OP_MODU
	} alu_op_e;

	// How the a/b logic result is combined with c
	typedef enum logic [MODW-1:0] {
		MOD_AND,
		MOD_ANDN,
		MOD_OR,
		MOD_ORN,
		MOD_XOR,
		MOD_XNOR
	} alu_mod_e;

	// ======================================================================
	// Opcode classes
	// ======================================================================
	function automatic logic is_mul_op(input alu_op_e op);
		return op inside {OP_MUL, OP_MULU, OP_MULH};
	endfunction

	function automatic logic is_div_op(input alu_op_e op);
		return op inside {OP_DIV, OP_DIVU, OP_MOD, OP_MODU};
	endfunction

endpackage

/* src/alu_unit.sv */
// Integer execute unit top level with operand registers and result select
// Holds the last result between result pulses
module alu_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     issue,
	input  alu_pkg::alu_op_e         op,
	input  alu_pkg::alu_mod_e        modf,
	input  logic [alu_pkg::WID-1:0]  a,
	input  logic [alu_pkg::WID-1:0]  b,
	input  logic [alu_pkg::WID-1:0]  c,
	input  logic [alu_pkg::IMMW-1:0] imm,
	output logic [alu_pkg::WID-1:0]  result,
	output logic                     result_valid,
	output logic                     div_by_zero,
	output logic                     busy
);
	import alu_pkg::*;

	alu_op_e op_q;
	alu_mod_e modf_q;
	logic [WID-1:0] a_q;
	logic [WID-1:0] b_q;
	logic [WID-1:0] c_q;
	logic [IMMW-1:0] imm_q;
	logic mul_start;
	logic div_start;
	logic timer_load;
	logic [7:0] timer_value;
	logic expired;
	logic mul_done;
	logic div_done;
	logic div_dbz;
	logic [WID-1:0] logic_y;
	logic [WID-1:0] mul_p;
	logic [WID-1:0] div_q;
	logic [WID-1:0] div_r;
	logic [WID-1:0] res_mux;
	logic [WID-1:0] result_q;

	// Every unit works from the operands captured at issue
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			op_q <= op;
			modf_q <= modf;
			a_q <= a;
			b_q <= b;
			c_q <= c;
			imm_q <= imm;
		end
	end

	alu_issue_ctrl u_ctrl (
		.clk(clk), .rst(rst), .issue(issue), .op(op), .expired(expired),
		.mul_start(mul_start), .div_start(div_start), .timer_load(timer_load),
		.timer_value(timer_value), .busy(busy), .result_valid(result_valid)
	);

	alu_cycle_timer u_timer (
		.clk(clk), .rst(rst), .load(timer_load), .value(timer_value), .expired(expired)
	);

	alu_logic_unit u_logic (
		.op(op_q), .modf(modf_q), .a(a_q), .b(b_q), .c(c_q), .imm(imm_q), .y(logic_y)
	);

	alu_multiplier u_mul (
		.clk(clk), .rst(rst), .start(mul_start), .sgn(op_q != OP_MULU),
		.high(op_q == OP_MULH), .a(a_q), .b(b_q), .product(mul_p), .done(mul_done)
	);

	alu_divider u_div (
		.clk(clk), .rst(rst), .start(div_start),
		.sgn((op_q == OP_DIV) || (op_q == OP_MOD)), .a(a_q), .b(b_q),
		.quotient(div_q), .remainder(div_r), .dbz(div_dbz), .done(div_done)
	);

	// ======================================================================
	// Result select and hold
	// ======================================================================
	always_comb
	begin
		if (is_mul_op(op_q))
			res_mux = mul_p;
		else if ((op_q == OP_DIV) || (op_q == OP_DIVU))
			res_mux = div_q;
		else if ((op_q == OP_MOD) || (op_q == OP_MODU))
			res_mux = div_r;
		else
			res_mux = logic_y;
	end

	always_ff @(posedge clk)
	begin
		if (result_valid)
			result_q <= res_mux;
	end

	assign result = result_valid ? res_mux : result_q;
	assign div_by_zero = is_div_op(op_q) && div_dbz;

	// The timer count must land on the cycle each unit finishes
	a_mul_aligned: assert property (@(posedge clk) disable iff (rst)
		(result_valid && is_mul_op(op_q)) |-> mul_done);
	a_div_aligned: assert property (@(posedge clk) disable iff (rst)
		(result_valid && is_div_op(op_q)) |-> div_done);

endmodule
